// File: project.f
src/exec_pkg.sv
src/issue_if.sv
src/wb_if.sv
src/issue_stage.sv
src/execute_alu.sv
src/wb_stage.sv
src/exec_cluster_top.sv
tb/exec_cluster_tb.sv

// File: tb/exec_cluster_tb.sv
// testbench for the execute cluster: clock, reset, reference model, checks, directed tests
`timescale 1ns/100ps

module exec_cluster_tb;

  localparam int NUM_STROBES = 88;
  localparam int CYCLE_LIMIT = 4 * NUM_STROBES + 50;

  typedef struct packed {
    exec_pkg::rob_tag_t tag;
    exec_pkg::word_t    result;
    logic               mispred;
    exec_pkg::word_t    redirect;
    logic               ctrl;
    int                 due;
  } exp_wb_t;

  logic                clk_i = 1'b0;
  logic                rst_n_i;
  logic                issue_valid_i;
  exec_pkg::alu_op_e   issue_alu_op_i;
  exec_pkg::br_op_e    issue_br_op_i;
  logic                issue_is_branch_i;
  logic                issue_is_jump_i;
  logic                issue_has_rs2_i;
  logic                issue_pred_taken_i;
  exec_pkg::word_t     issue_pc_i;
  exec_pkg::word_t     issue_imm_i;
  exec_pkg::word_t     issue_rs1_i;
  exec_pkg::word_t     issue_rs2_i;
  logic                issue_rs1_fwd_i;
  logic                issue_rs2_fwd_i;
  exec_pkg::rob_tag_t  issue_tag_i;
  logic                wb_valid_o;
  exec_pkg::rob_tag_t  wb_tag_o;
  exec_pkg::word_t     wb_result_o;
  logic                wb_mispred_o;
  exec_pkg::word_t     wb_redirect_pc_o;

  integer              seed = 22554;
  int                  cyc_cnt = 0;
  int                  neg_cnt = 0;
  int                  last_mp_cyc = -10;
  exec_pkg::rob_tag_t  next_tag = '0;
  exec_pkg::word_t     last_result = '0;
  exp_wb_t             exp_q[$];

  exec_cluster_top UUT (.*);

  always #2 clk_i = ~clk_i;

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_word(input string name, input exec_pkg::word_t exp,
                            input exec_pkg::word_t act);
    if (exp !== act) begin
      $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
      report_fail("word mismatch on writeback bus");
    end
  endtask

  task automatic check_tag(input string name, input exec_pkg::rob_tag_t exp,
                           input exec_pkg::rob_tag_t act);
    if (exp !== act) begin
      $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
      report_fail("tag mismatch on writeback bus");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("[FAIL] %0t %s expected %b got %b", $time, name, exp, act);
      report_fail("bit mismatch on writeback bus");
    end
  endtask

  // reference behavior of one operation
  function automatic void model(input exec_pkg::alu_op_e op, input exec_pkg::br_op_e br,
                                input logic is_br, input logic is_j, input logic has_rs2,
                                input logic pred, input exec_pkg::word_t pc,
                                input exec_pkg::word_t imm, input exec_pkg::word_t rs1,
                                input exec_pkg::word_t rs2, output exec_pkg::word_t res,
                                output logic mp, output exec_pkg::word_t redir);
    exec_pkg::word_t a;
    exec_pkg::word_t b;
    exec_pkg::word_t target;
    logic            taken;
    a = (op == exec_pkg::ALU_AUIPC) ? pc : rs1;
    b = has_rs2 ? rs2 : imm;
    case (op)
      exec_pkg::ALU_ADD, exec_pkg::ALU_AUIPC: res = a + b;
      exec_pkg::ALU_SUB:  res = a - b;
      exec_pkg::ALU_LUI:  res = imm;
      exec_pkg::ALU_AND:  res = a & b;
      exec_pkg::ALU_OR:   res = a | b;
      exec_pkg::ALU_XOR:  res = a ^ b;
      exec_pkg::ALU_SLL:  res = a << b[4:0];
      exec_pkg::ALU_SRL:  res = a >> b[4:0];
      exec_pkg::ALU_SRA:  res = $signed(a) >>> b[4:0];
      exec_pkg::ALU_SLT:  res = {31'd0, $signed(a) < $signed(b)};
      default:            res = {31'd0, a < b};
    endcase
    taken = is_j;
    if (is_br) begin
      case (br)
        exec_pkg::BR_EQ:  taken = (rs1 == rs2);
        exec_pkg::BR_NE:  taken = (rs1 != rs2);
        exec_pkg::BR_LT:  taken = ($signed(rs1) < $signed(rs2));
        exec_pkg::BR_GE:  taken = ($signed(rs1) >= $signed(rs2));
        exec_pkg::BR_LTU: taken = (rs1 < rs2);
        default:          taken = (rs1 >= rs2);
      endcase
    end
    if (is_j)
      res = pc + 32'd4;
    target = (br == exec_pkg::BR_JALR) ? rs1 + imm : pc + imm;
    mp = (is_br || is_j) && (taken != pred);
    redir = taken ? target : pc + 32'd4;
  endfunction

  // strobe one op on the next edge and queue its expected writeback
  task automatic send_op(input exec_pkg::alu_op_e op, input exec_pkg::br_op_e br,
                         input logic is_br, input logic is_j, input logic has_rs2,
                         input logic pred, input exec_pkg::word_t pc,
                         input exec_pkg::word_t imm, input exec_pkg::word_t rs1,
                         input exec_pkg::word_t rs2, input logic f1, input logic f2);
    exp_wb_t e;
    exec_pkg::word_t a1;
    exec_pkg::word_t a2;
    @(posedge clk_i);
    issue_valid_i      <= 1'b1;
    issue_alu_op_i     <= op;
    issue_br_op_i      <= br;
    issue_is_branch_i  <= is_br;
    issue_is_jump_i    <= is_j;
    issue_has_rs2_i    <= has_rs2;
    issue_pred_taken_i <= pred;
    issue_pc_i         <= pc;
    issue_imm_i        <= imm;
    issue_rs1_i        <= rs1;
    issue_rs2_i        <= rs2;
    issue_rs1_fwd_i    <= f1;
    issue_rs2_fwd_i    <= f2;
    issue_tag_i        <= next_tag;
    a1 = f1 ? last_result : rs1;
    a2 = f2 ? last_result : rs2;
    model(op, br, is_br, is_j, has_rs2, pred, pc, imm, a1, a2, e.result, e.mispred,
          e.redirect);
    e.tag  = next_tag;
    e.ctrl = is_br || is_j;
    e.due  = neg_cnt + exec_pkg::EXEC_LAT;
    next_tag = next_tag + 1'b1;
    // the two strobes after a mispredict are squashed
    if (!((neg_cnt - last_mp_cyc) inside {1, 2})) begin
      exp_q.push_back(e);
      last_result = e.result;
      if (e.mispred)
        last_mp_cyc = neg_cnt;
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk_i);
      issue_valid_i   <= 1'b0;
      issue_rs1_fwd_i <= 1'b0;
      issue_rs2_fwd_i <= 1'b0;
    end
  endtask

  task automatic test_reset_quiet();
    idle(10);
  endtask

  task automatic test_alu_ops();
    for (int i = 0; i < 12; i++) begin
      for (int r = 0; r < 2; r++) begin
        send_op(exec_pkg::alu_op_e'(i), exec_pkg::BR_EQ, 1'b0, 1'b0, r[0], 1'b0,
                $random(seed), $random(seed), $random(seed), $random(seed), 1'b0, 1'b0);
      end
    end
    idle(3);
  endtask

  task automatic test_branches();
    exec_pkg::word_t lhs[4];
    exec_pkg::word_t rhs[4];
    lhs = '{32'h0000_1234, 32'hFFFF_FFF0, 32'h0000_0010, 32'h0000_0005};
    rhs = '{32'h0000_1234, 32'h0000_0010, 32'hFFFF_FFF0, 32'h0000_0007};
    for (int c = 0; c < 6; c++) begin
      for (int p = 0; p < 4; p++) begin
        for (int t = 0; t < 2; t++) begin
          send_op(exec_pkg::ALU_ADD, exec_pkg::br_op_e'(c), 1'b1, 1'b0, 1'b1, t[0],
                  32'h0000_8000 + c * 64, 32'h0000_0100, lhs[p], rhs[p], 1'b0, 1'b0);
          // gap keeps a flush from touching the next branch
          idle(2);
        end
      end
    end
  endtask

  task automatic test_jumps();
    for (int t = 0; t < 2; t++) begin
      send_op(exec_pkg::ALU_ADD, exec_pkg::BR_JAL, 1'b0, 1'b1, 1'b0, t[0],
              32'h0000_4000, 32'h0000_0200, $random(seed), $random(seed), 1'b0, 1'b0);
      idle(2);
      send_op(exec_pkg::ALU_ADD, exec_pkg::BR_JALR, 1'b0, 1'b1, 1'b0, t[0],
              32'h0000_5000, 32'hFFFF_FFFC, 32'h0001_0000, $random(seed), 1'b0, 1'b0);
      idle(2);
    end
  endtask

  task automatic test_forwarding();
    repeat (2) begin
      send_op(exec_pkg::ALU_ADD, exec_pkg::BR_EQ, 1'b0, 1'b0, 1'b1, 1'b0, '0, '0,
              $random(seed), $random(seed), 1'b0, 1'b0);
      send_op(exec_pkg::ALU_ADD, exec_pkg::BR_EQ, 1'b0, 1'b0, 1'b1, 1'b0, '0, '0,
              $random(seed), $random(seed), 1'b1, 1'b0);
      send_op(exec_pkg::ALU_SUB, exec_pkg::BR_EQ, 1'b0, 1'b0, 1'b1, 1'b0, '0, '0,
              $random(seed), $random(seed), 1'b0, 1'b1);
      send_op(exec_pkg::ALU_XOR, exec_pkg::BR_EQ, 1'b0, 1'b0, 1'b1, 1'b0, '0, '0,
              $random(seed), $random(seed), 1'b1, 1'b1);
    end
    idle(3);
  endtask

  task automatic test_flush();
    // predicted taken but operands differ, so BEQ mispredicts
    send_op(exec_pkg::ALU_ADD, exec_pkg::BR_EQ, 1'b1, 1'b0, 1'b1, 1'b1,
            32'h0000_9000, 32'h0000_0040, 32'h1, 32'h2, 1'b0, 1'b0);
    repeat (3) begin
      send_op(exec_pkg::ALU_ADD, exec_pkg::BR_EQ, 1'b0, 1'b0, 1'b1, 1'b0, '0, '0,
              $random(seed), $random(seed), 1'b0, 1'b0);
    end
    idle(4);
  endtask

  // writeback monitor, sampled away from the driving edge
  always @(negedge clk_i) begin
    exp_wb_t e;
    neg_cnt <= neg_cnt + 1;
    if (wb_valid_o === 1'b1) begin
      if (exp_q.size() == 0)
        report_fail("writeback arrived when none was expected");
      e = exp_q.pop_front();
      if (e.due != neg_cnt)
        report_fail("writeback arrived in the wrong cycle");
      check_tag("wb_tag_o", e.tag, wb_tag_o);
      check_word("wb_result_o", e.result, wb_result_o);
      check_bit("wb_mispred_o", e.mispred, wb_mispred_o);
      if (e.ctrl)
        check_word("wb_redirect_pc_o", e.redirect, wb_redirect_pc_o);
    end else begin
      check_bit("wb_valid_o", 1'b0, wb_valid_o);
      check_bit("wb_mispred_o", 1'b0, wb_mispred_o);
      if (exp_q.size() != 0 && exp_q[0].due <= neg_cnt)
        report_fail("expected writeback did not arrive");
    end
  end

  always @(posedge clk_i) begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt >= CYCLE_LIMIT)
      report_fail("timeout, run exceeded its cycle limit");
  end

  initial begin
    rst_n_i            = 1'b0;
    issue_valid_i      = 1'b0;
    issue_alu_op_i     = exec_pkg::ALU_ADD;
    issue_br_op_i      = exec_pkg::BR_EQ;
    issue_is_branch_i  = 1'b0;
    issue_is_jump_i    = 1'b0;
    issue_has_rs2_i    = 1'b0;
    issue_pred_taken_i = 1'b0;
    issue_pc_i         = '0;
    issue_imm_i        = '0;
    issue_rs1_i        = '0;
    issue_rs2_i        = '0;
    issue_rs1_fwd_i    = 1'b0;
    issue_rs2_fwd_i    = 1'b0;
    issue_tag_i        = '0;
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;
    test_reset_quiet();
    test_alu_ops();
    test_branches();
    test_jumps();
    test_forwarding();
    test_flush();
    if (exp_q.size() == 0) begin
      $display("test passed");
      $finish;
    end else begin
      report_fail("writebacks still outstanding at end of run");
    end
  end

endmodule

// File: src/exec_cluster_top.sv
// execute cluster top: issue register, ALU and writeback register with plain ports
`timescale 1ns/100ps

module exec_cluster_top (
  input  logic                clk_i,
  input  logic                rst_n_i,

  // issue strobe, one op per cycle
  input  logic                issue_valid_i,
  input  exec_pkg::alu_op_e   issue_alu_op_i,
  input  exec_pkg::br_op_e    issue_br_op_i,
  input  logic                issue_is_branch_i,
  input  logic                issue_is_jump_i,
  input  logic                issue_has_rs2_i,
  input  logic                issue_pred_taken_i,
  input  exec_pkg::word_t     issue_pc_i,
  input  exec_pkg::word_t     issue_imm_i,
  input  exec_pkg::word_t     issue_rs1_i,
  input  exec_pkg::word_t     issue_rs2_i,
  input  logic                issue_rs1_fwd_i,
  input  logic                issue_rs2_fwd_i,
  input  exec_pkg::rob_tag_t  issue_tag_i,

  // writeback towards the ROB
  output logic                wb_valid_o,
  output exec_pkg::rob_tag_t  wb_tag_o,
  output exec_pkg::word_t     wb_result_o,
  output logic                wb_mispred_o,
  output exec_pkg::word_t     wb_redirect_pc_o
);

  exec_pkg::uop_t      issue_uop;
  logic                alu_valid;
  exec_pkg::rob_tag_t  alu_tag;
  exec_pkg::word_t     alu_result;
  logic                alu_mispred;
  exec_pkg::word_t     alu_redirect_pc;

  // gather the decoded fields into one micro-op
  assign issue_uop.alu_op     = issue_alu_op_i;
  assign issue_uop.br_op      = issue_br_op_i;
  assign issue_uop.is_branch  = issue_is_branch_i;
  assign issue_uop.is_jump    = issue_is_jump_i;
  assign issue_uop.has_rs2    = issue_has_rs2_i;
  assign issue_uop.pred_taken = issue_pred_taken_i;
  assign issue_uop.pc         = issue_pc_i;
  assign issue_uop.imm        = issue_imm_i;

  issue_if u_iss_if (.clk_i(clk_i));
  wb_if    u_wb_if ();

  issue_stage u_issue_stage (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .issue_valid_i   (issue_valid_i),
    .issue_uop_i     (issue_uop),
    .issue_rs1_i     (issue_rs1_i),
    .issue_rs2_i     (issue_rs2_i),
    .issue_rs1_fwd_i (issue_rs1_fwd_i),
    .issue_rs2_fwd_i (issue_rs2_fwd_i),
    .issue_tag_i     (issue_tag_i),
    .iss             (u_iss_if.src),
    .byp             (u_wb_if.byp)
  );

  execute_alu u_execute_alu (
    .iss               (u_iss_if.dst),
    .alu_valid_o       (alu_valid),
    .alu_tag_o         (alu_tag),
    .alu_result_o      (alu_result),
    .alu_mispred_o     (alu_mispred),
    .alu_redirect_pc_o (alu_redirect_pc)
  );

  wb_stage u_wb_stage (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .alu_valid_i       (alu_valid),
    .alu_tag_i         (alu_tag),
    .alu_result_i      (alu_result),
    .alu_mispred_i     (alu_mispred),
    .alu_redirect_pc_i (alu_redirect_pc),
    .wb                (u_wb_if.src)
  );

  assign wb_valid_o       = u_wb_if.valid;
  assign wb_tag_o         = u_wb_if.tag;
  assign wb_result_o      = u_wb_if.result;
  assign wb_mispred_o     = u_wb_if.mispred;
  assign wb_redirect_pc_o = u_wb_if.redirect_pc;

endmodule

// File: src/wb_stage.sv
// writeback register driving the result bus, bypass source and flush
`timescale 1ns/100ps

module wb_stage (
  input  logic                clk_i,
  input  logic                rst_n_i,

  // combinational ALU outputs
  input  logic                alu_valid_i,
  input  exec_pkg::rob_tag_t  alu_tag_i,
  input  exec_pkg::word_t     alu_result_i,
  input  logic                alu_mispred_i,
  input  exec_pkg::word_t     alu_redirect_pc_i,

  wb_if.src                   wb
);

  logic                valid_q;
  logic                mispred_q;
  exec_pkg::rob_tag_t  tag_q;
  exec_pkg::word_t     result_q;
  exec_pkg::word_t     redirect_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q    <= 1'b0;
      mispred_q  <= 1'b0;
      tag_q      <= '0;
      result_q   <= '0;
      redirect_q <= '0;
    end else begin
      valid_q   <= alu_valid_i;
      // ALU qualifies its mispredict with valid
      mispred_q <= alu_mispred_i;
      if (alu_valid_i) begin
        tag_q      <= alu_tag_i;
        result_q   <= alu_result_i;
        redirect_q <= alu_redirect_pc_i;
      end
    end
  end

  assign wb.valid       = valid_q;
  assign wb.tag         = tag_q;
  assign wb.result      = result_q;
  assign wb.mispred     = mispred_q;
  assign wb.redirect_pc = redirect_q;

  // the issue side relies on a flush never appearing alone
  a_mispred_valid: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    wb.mispred |-> wb.valid
  ) else $error("mispredict on writeback bus without a valid op");

endmodule

// File: src/execute_alu.sv
// integer ALU: operand select, arithmetic and logic ops, branch resolve, mispredict check
`timescale 1ns/100ps

module execute_alu (
  issue_if.dst                iss,

  // towards the writeback register
  output logic                alu_valid_o,
  output exec_pkg::rob_tag_t  alu_tag_o,
  output exec_pkg::word_t     alu_result_o,
  output logic                alu_mispred_o,
  output exec_pkg::word_t     alu_redirect_pc_o
);

  exec_pkg::word_t   op_a;
  exec_pkg::word_t   op_b;
  exec_pkg::shamt_t  shamt;
  exec_pkg::word_t   alu_res;
  exec_pkg::word_t   link_pc;
  exec_pkg::word_t   br_target;
  logic              br_take;
  logic              is_ctrl;

  // AUIPC adds to the pc, everything else works on rs1
  assign op_a = (iss.uop.alu_op == exec_pkg::ALU_AUIPC) ? iss.uop.pc : iss.op_rs1;
  assign op_b = iss.uop.has_rs2 ? iss.op_rs2 : iss.uop.imm;

  assign shamt = op_b[exec_pkg::SHAMT_W-1:0];

  always_comb begin
    alu_res = '0;
    unique case (iss.uop.alu_op)
      exec_pkg::ALU_ADD:   alu_res = op_a + op_b;
      exec_pkg::ALU_SUB:   alu_res = op_a - op_b;
      exec_pkg::ALU_LUI:   alu_res = iss.uop.imm;
      exec_pkg::ALU_AUIPC: alu_res = op_a + op_b;
      exec_pkg::ALU_AND:   alu_res = op_a & op_b;
      exec_pkg::ALU_OR:    alu_res = op_a | op_b;
      exec_pkg::ALU_XOR:   alu_res = op_a ^ op_b;
      exec_pkg::ALU_SLL:   alu_res = op_a << shamt;
      exec_pkg::ALU_SRL:   alu_res = op_a >> shamt;
      exec_pkg::ALU_SRA:   alu_res = $signed(op_a) >>> shamt;
      exec_pkg::ALU_SLT:   alu_res = exec_pkg::word_t'($signed(op_a) < $signed(op_b));
      exec_pkg::ALU_SLTU:  alu_res = exec_pkg::word_t'(op_a < op_b);
      default:             alu_res = '0;
    endcase
  end

  // return address for jumps, fall-through for not-taken branches
  assign link_pc = iss.uop.pc + exec_pkg::LINK_OFFSET;

  // JALR is register relative, the rest pc relative
  assign br_target = (iss.uop.br_op == exec_pkg::BR_JALR) ?
                     (iss.op_rs1 + iss.uop.imm) : (iss.uop.pc + iss.uop.imm);

  // branch compares always use the register operands
  always_comb begin
    br_take = 1'b0;
    if (iss.uop.is_branch) begin
      unique case (iss.uop.br_op)
        exec_pkg::BR_EQ:  br_take = (iss.op_rs1 == iss.op_rs2);
        exec_pkg::BR_NE:  br_take = (iss.op_rs1 != iss.op_rs2);
        exec_pkg::BR_LT:  br_take = ($signed(iss.op_rs1) <  $signed(iss.op_rs2));
        exec_pkg::BR_GE:  br_take = ($signed(iss.op_rs1) >= $signed(iss.op_rs2));
        exec_pkg::BR_LTU: br_take = (iss.op_rs1 <  iss.op_rs2);
        exec_pkg::BR_GEU: br_take = (iss.op_rs1 >= iss.op_rs2);
        default:          br_take = 1'b0;
      endcase
    end else if (iss.uop.is_jump) begin
      br_take = 1'b1;
    end
  end

  assign is_ctrl = iss.uop.is_branch || iss.uop.is_jump;

  // wrong direction either way needs a redirect
  assign alu_mispred_o     = iss.valid && is_ctrl && (br_take != iss.uop.pred_taken);
  assign alu_redirect_pc_o = br_take ? br_target : link_pc;

  assign alu_valid_o  = iss.valid;
  assign alu_tag_o    = iss.tag;
  assign alu_result_o = iss.uop.is_jump ? link_pc : alu_res;

  // decoder never marks an op as both kinds of control transfer
  a_branch_jump_excl: assert property (
    @(posedge iss.clk_i)
    iss.valid |-> !(iss.uop.is_branch && iss.uop.is_jump)
  ) else $error("op marked as both branch and jump");

endmodule

// File: src/issue_stage.sv
// issue register with operand forwarding from writeback and flush squash
`timescale 1ns/100ps

module issue_stage (
  input  logic                clk_i,
  input  logic                rst_n_i,

  // issue strobe from the scheduler
  input  logic                issue_valid_i,
  input  exec_pkg::uop_t      issue_uop_i,
  input  exec_pkg::word_t     issue_rs1_i,
  input  exec_pkg::word_t     issue_rs2_i,
  input  logic                issue_rs1_fwd_i,
  input  logic                issue_rs2_fwd_i,
  input  exec_pkg::rob_tag_t  issue_tag_i,

  issue_if.src                iss,
  wb_if.byp                   byp
);

  logic                valid_q;
  exec_pkg::uop_t      uop_q;
  exec_pkg::word_t     rs1_q;
  exec_pkg::word_t     rs2_q;
  logic                rs1_fwd_q;
  logic                rs2_fwd_q;
  exec_pkg::rob_tag_t  tag_q;
  logic                flush;

  // a mispredicting op on the writeback bus kills everything younger
  assign flush = byp.valid && byp.mispred;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      // strobe arriving during a flush is younger, so drop it
      valid_q <= issue_valid_i && !flush;
    end
  end

  // operation payload, only meaningful with valid_q
  always_ff @(posedge clk_i) begin
    if (issue_valid_i) begin
      uop_q     <= issue_uop_i;
      rs1_q     <= issue_rs1_i;
      rs2_q     <= issue_rs2_i;
      rs1_fwd_q <= issue_rs1_fwd_i;
      rs2_fwd_q <= issue_rs2_fwd_i;
      tag_q     <= issue_tag_i;
    end
  end

  // held op is squashed in the same cycle the flush shows up
  assign iss.valid = valid_q && !flush;
  assign iss.uop   = uop_q;
  assign iss.tag   = tag_q;

  // forwarded operands come from the op one cycle ahead
  assign iss.op_rs1 = rs1_fwd_q ? byp.result : rs1_q;
  assign iss.op_rs2 = rs2_fwd_q ? byp.result : rs2_q;

  // a forwarded operand needs a producer on the writeback bus
  a_fwd_has_producer: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (valid_q && (rs1_fwd_q || rs2_fwd_q)) |-> byp.valid
  ) else $error("forward flag set without a valid writeback to bypass");

endmodule

// File: src/wb_if.sv
// writeback bundle: result, tag, mispredict flush and redirect address
`timescale 1ns/100ps

interface wb_if;

  logic                valid;
  exec_pkg::rob_tag_t  tag;
  exec_pkg::word_t     result;
  // flush for younger ops in the cluster
  logic                mispred;
  exec_pkg::word_t     redirect_pc;

  // driven by the writeback register
  modport src (
    output valid, tag, result, mispred, redirect_pc
  );

  // bypass and flush view for the issue side
  modport byp (
    input valid, result, mispred
  );

endinterface

// File: src/issue_if.sv
// issue bundle: registered micro-op, forwarded operands and ROB tag
`timescale 1ns/100ps

interface issue_if (
  input logic clk_i
);

  logic                valid;
  exec_pkg::uop_t      uop;
  exec_pkg::word_t     op_rs1;
  exec_pkg::word_t     op_rs2;
  exec_pkg::rob_tag_t  tag;

  // driven by the issue register
  modport src (
    output valid, uop, op_rs1, op_rs2, tag
  );

  // read by the ALU, clock only for checks
  modport dst (
    input clk_i, valid, uop, op_rs1, op_rs2, tag
  );

endinterface

// File: src/exec_pkg.sv
// execute cluster package: widths, word and tag types, op enums, micro-op struct, latency
package exec_pkg;

  // datapath and ROB index widths
  localparam int XLEN  = 32;
  localparam int TAG_W = 6;

  // shift amount field taken from operand B
  localparam int SHAMT_W = $clog2(XLEN);

  // cycles from issue strobe to writeback bus
  localparam int EXEC_LAT = 2;

  typedef logic [XLEN-1:0]    word_t;
  typedef logic [TAG_W-1:0]   rob_tag_t;
  typedef logic [SHAMT_W-1:0] shamt_t;

  // size of one instruction, used for the link and fall-through address
  localparam word_t LINK_OFFSET = word_t'(4);

  // integer ALU operations
  typedef enum logic [3:0] {
    ALU_ADD   = 4'd0,
    ALU_SUB   = 4'd1,
    ALU_LUI   = 4'd2,
    ALU_AUIPC = 4'd3,
    ALU_AND   = 4'd4,
    ALU_OR    = 4'd5,
    ALU_XOR   = 4'd6,
    ALU_SLL   = 4'd7,
    ALU_SRL   = 4'd8,
    ALU_SRA   = 4'd9,
    ALU_SLT   = 4'd10,
    ALU_SLTU  = 4'd11
  } alu_op_e;

  // branch conditions and jump kinds
  typedef enum logic [2:0] {
    BR_EQ   = 3'd0,
    BR_NE   = 3'd1,
    BR_LT   = 3'd2,
    BR_GE   = 3'd3,
    BR_LTU  = 3'd4,
    BR_GEU  = 3'd5,
    BR_JAL  = 3'd6,
    BR_JALR = 3'd7
  } br_op_e;

  // decoded micro-op as it leaves the issue queue
  typedef struct packed {
    alu_op_e alu_op;
    br_op_e  br_op;
    logic    is_branch;
    logic    is_jump;
    // operand B from rs2, else from imm
    logic    has_rs2;
    // direction the front end followed
    logic    pred_taken;
    word_t   pc;
    word_t   imm;
  } uop_t;

endpackage
